// ==== logic/hbm_pkg.sv ====
// hbm channel harness package: dram geometry, word types and address reorder
package hbm_pkg;

  // --------------------------------------------------------------------------
  // channel geometry
  // --------------------------------------------------------------------------
  localparam int BA_WIDTH          = 2;
  localparam int BG_WIDTH          = 2;
  localparam int ROW_WIDTH         = 4;
  localparam int COL_WIDTH         = 5;
  localparam int BYTE_OFFSET_WIDTH = 2;
  localparam int DATA_WIDTH        = 32;

  localparam int CH_ADDR_WIDTH   = BA_WIDTH + BG_WIDTH + ROW_WIDTH + COL_WIDTH
                                   + BYTE_OFFSET_WIDTH;
  localparam int WORD_ADDR_WIDTH = CH_ADDR_WIDTH - BYTE_OFFSET_WIDTH;
  localparam int NUM_WORDS       = 2 ** WORD_ADDR_WIDTH;

  // harness timing
  localparam int RESET_DEPTH     = 3;
  localparam int HOLD_CNT_WIDTH  = 2;
  localparam int READ_LATENCY    = 4;
  localparam int RESP_FIFO_DEPTH = 4;
  localparam int FIFO_PTR_WIDTH  = 2;
  localparam int CREDIT_WIDTH    = 3;

  typedef logic [CH_ADDR_WIDTH-1:0]   ch_addr_t;
  typedef logic [WORD_ADDR_WIDTH-1:0] word_addr_t;
  typedef logic [DATA_WIDTH-1:0]      dram_data_t;
  typedef logic [CREDIT_WIDTH-1:0]    credit_t;

  typedef enum logic [1:0] {
    ST_HOLD,
    ST_CLEAR,
    ST_READY
  } ctrl_state_e;

  // --------------------------------------------------------------------------
  // address reorder
  // --------------------------------------------------------------------------
  // cache side is ba-bg-ro-co-bo, the dram model wants ro-bg-ba-co-bo
  function automatic ch_addr_t to_dram_addr(ch_addr_t cache_addr);
    logic [BA_WIDTH-1:0]          ba;
    logic [BG_WIDTH-1:0]          bg;
    logic [ROW_WIDTH-1:0]         ro;
    logic [COL_WIDTH-1:0]         co;
    logic [BYTE_OFFSET_WIDTH-1:0] bo;
    {ba, bg, ro, co, bo} = cache_addr;
    return {ro, bg, ba, co, bo};
  endfunction

  // read-done address back to cache order
  function automatic ch_addr_t to_cache_addr(ch_addr_t dram_addr);
    logic [BA_WIDTH-1:0]          ba;
    logic [BG_WIDTH-1:0]          bg;
    logic [ROW_WIDTH-1:0]         ro;
    logic [COL_WIDTH-1:0]         co;
    logic [BYTE_OFFSET_WIDTH-1:0] bo;
    {ro, bg, ba, co, bo} = dram_addr;
    return {ba, bg, ro, co, bo};
  endfunction

endpackage

// ==== logic/dram_req_ctrl.sv ====
// request control: reset hold, memory clear, request acceptance and read credits
`timescale 1ns/1ps

module dram_req_ctrl (
  input  logic                clk_i,
  input  logic                rst_n_i,

  input  logic                req_v_i,
  input  logic                req_write_not_read_i,
  input  hbm_pkg::ch_addr_t   req_ch_addr_i,
  input  hbm_pkg::dram_data_t req_data_i,
  output logic                req_yumi_o,

  input  logic                resp_v_i,
  input  logic                resp_yumi_i,
  output logic                ready_o,

  output logic                cmd_v_o,
  output logic                cmd_we_o,
  output hbm_pkg::ch_addr_t   cmd_addr_o,
  output hbm_pkg::dram_data_t cmd_data_o
);

  import hbm_pkg::*;

  ctrl_state_e               state_r;
  logic [HOLD_CNT_WIDTH-1:0] hold_cnt_r;
  word_addr_t                clear_cnt_r;
  credit_t                   credit_r;

  logic clearing;
  logic credit_ok;
  logic rd_take;
  logic rd_give;

  assign ready_o  = (state_r == ST_READY);
  assign clearing = (state_r == ST_CLEAR);

  // one credit per read in flight or waiting in the response queue
  assign credit_ok  = (credit_r < credit_t'(RESP_FIFO_DEPTH));
  assign req_yumi_o = req_v_i & ready_o & credit_ok;

  assign rd_take = req_yumi_o & ~req_write_not_read_i;
  assign rd_give = resp_v_i & resp_yumi_i;

  // --------------------------------------------------------------------------
  // channel command
  // --------------------------------------------------------------------------
  always_comb begin
    if (clearing) begin
      // clear counter already indexes storage, so no reorder here
      cmd_v_o    = 1'b1;
      cmd_we_o   = 1'b1;
      cmd_addr_o = {clear_cnt_r, {BYTE_OFFSET_WIDTH{1'b0}}};
      cmd_data_o = '0;
    end else begin
      cmd_v_o    = req_yumi_o;
      cmd_we_o   = req_write_not_read_i;
      cmd_addr_o = to_dram_addr(req_ch_addr_i);
      cmd_data_o = req_data_i;
    end
  end

  // --------------------------------------------------------------------------
  // state machine
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r     <= ST_HOLD;
      hold_cnt_r  <= '0;
      clear_cnt_r <= '0;
    end else begin
      case (state_r)
        ST_HOLD: begin
          hold_cnt_r <= hold_cnt_r + 1'b1;
          if (hold_cnt_r == HOLD_CNT_WIDTH'(RESET_DEPTH - 1)) begin
            state_r <= ST_CLEAR;
          end
        end
        ST_CLEAR: begin
          // one zero word per cycle
          clear_cnt_r <= clear_cnt_r + 1'b1;
          if (clear_cnt_r == word_addr_t'(NUM_WORDS - 1)) begin
            state_r <= ST_READY;
          end
        end
        default: begin
          state_r <= ST_READY;
        end
      endcase
    end
  end

  // credit count
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_r <= '0;
    end else begin
      credit_r <= credit_r + credit_t'(rd_take) - credit_t'(rd_give);
    end
  end

endmodule

// ==== logic/dram_channel_model.sv ====
// single-channel dram model: word storage with a fixed-latency read pipeline
`timescale 1ns/1ps

module dram_channel_model (
  input  logic                clk_i,
  input  logic                rst_n_i,

  input  logic                cmd_v_i,
  input  logic                cmd_we_i,
  input  hbm_pkg::ch_addr_t   cmd_addr_i,
  input  hbm_pkg::dram_data_t cmd_data_i,

  output logic                rd_v_o,
  output hbm_pkg::dram_data_t rd_data_o,
  output hbm_pkg::ch_addr_t   rd_addr_o
);

  import hbm_pkg::*;

  dram_data_t mem [NUM_WORDS];

  word_addr_t word_idx;
  logic       rd_req;

  logic [READ_LATENCY-1:0] pipe_v_r;
  dram_data_t              pipe_data_r [READ_LATENCY];
  ch_addr_t                pipe_addr_r [READ_LATENCY];

  // byte offset dropped, storage is word addressed
  assign word_idx = cmd_addr_i[CH_ADDR_WIDTH-1:BYTE_OFFSET_WIDTH];
  assign rd_req   = cmd_v_i & ~cmd_we_i;

  // --------------------------------------------------------------------------
  // storage
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (cmd_v_i && cmd_we_i) begin
      mem[word_idx] <= cmd_data_i;
    end
  end

  // --------------------------------------------------------------------------
  // read pipeline
  // --------------------------------------------------------------------------
  // valids only, several reads may be in flight
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pipe_v_r <= '0;
    end else begin
      pipe_v_r <= {pipe_v_r[READ_LATENCY-2:0], rd_req};
    end
  end

  // stage 0 samples storage at the accepting edge
  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      pipe_data_r[0] <= mem[word_idx];
      pipe_addr_r[0] <= cmd_addr_i;
    end
    for (int i = 1; i < READ_LATENCY; i++) begin
      pipe_data_r[i] <= pipe_data_r[i-1];
      pipe_addr_r[i] <= pipe_addr_r[i-1];
    end
  end

  // read done, still in dram order
  assign rd_v_o    = pipe_v_r[READ_LATENCY-1];
  assign rd_data_o = pipe_data_r[READ_LATENCY-1];
  assign rd_addr_o = pipe_addr_r[READ_LATENCY-1];

endmodule

// ==== logic/read_resp_fifo.sv ====
// read response queue, returns each read-done address in cache order
`timescale 1ns/1ps

module read_resp_fifo (
  input  logic                clk_i,
  input  logic                rst_n_i,

  input  logic                rd_v_i,
  input  hbm_pkg::dram_data_t rd_data_i,
  input  hbm_pkg::ch_addr_t   rd_addr_i,

  output logic                resp_v_o,
  output hbm_pkg::dram_data_t resp_data_o,
  output hbm_pkg::ch_addr_t   resp_ch_addr_o,
  input  logic                resp_yumi_i
);

  import hbm_pkg::*;

  dram_data_t data_q [RESP_FIFO_DEPTH];
  ch_addr_t   addr_q [RESP_FIFO_DEPTH];

  logic [FIFO_PTR_WIDTH-1:0] wr_ptr_r;
  logic [FIFO_PTR_WIDTH-1:0] rd_ptr_r;
  credit_t                   count_r;

  logic push;
  logic pop;

  // no full check, the request side credits keep this from overflowing
  assign push = rd_v_i;
  assign pop  = resp_v_o & resp_yumi_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      data_q[wr_ptr_r] <= rd_data_i;
      addr_q[wr_ptr_r] <= to_cache_addr(rd_addr_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      count_r <= count_r + credit_t'(push) - credit_t'(pop);
    end
  end

  // head of queue
  assign resp_v_o       = (count_r != '0);
  assign resp_data_o    = data_q[rd_ptr_r];
  assign resp_ch_addr_o = addr_q[rd_ptr_r];

endmodule

// ==== logic/hbm_test_bridge.sv ====
// hbm channel harness top: request control, dram channel model and response queue
`timescale 1ns/1ps

module hbm_test_bridge (
  input  logic                clk_i,
  input  logic                rst_n_i,

  output logic                ready_o,

  // requester side
  input  logic                req_v_i,
  input  logic                req_write_not_read_i,
  input  hbm_pkg::ch_addr_t   req_ch_addr_i,
  input  hbm_pkg::dram_data_t req_data_i,
  output logic                req_yumi_o,

  // response side
  output logic                resp_v_o,
  output hbm_pkg::dram_data_t resp_data_o,
  output hbm_pkg::ch_addr_t   resp_ch_addr_o,
  input  logic                resp_yumi_i
);

  import hbm_pkg::*;

  // channel command, dram order
  logic       cmd_v;
  logic       cmd_we;
  ch_addr_t   cmd_addr;
  dram_data_t cmd_data;

  // read done
  logic       rd_v;
  dram_data_t rd_data;
  ch_addr_t   rd_addr;

  dram_req_ctrl ctrl (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .req_v_i              (req_v_i),
    .req_write_not_read_i (req_write_not_read_i),
    .req_ch_addr_i        (req_ch_addr_i),
    .req_data_i           (req_data_i),
    .req_yumi_o           (req_yumi_o),
    .resp_v_i             (resp_v_o),
    .resp_yumi_i          (resp_yumi_i),
    .ready_o              (ready_o),
    .cmd_v_o              (cmd_v),
    .cmd_we_o             (cmd_we),
    .cmd_addr_o           (cmd_addr),
    .cmd_data_o           (cmd_data)
  );

  dram_channel_model chan (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cmd_v_i    (cmd_v),
    .cmd_we_i   (cmd_we),
    .cmd_addr_i (cmd_addr),
    .cmd_data_i (cmd_data),
    .rd_v_o     (rd_v),
    .rd_data_o  (rd_data),
    .rd_addr_o  (rd_addr)
  );

  read_resp_fifo resp_q (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .rd_v_i         (rd_v),
    .rd_data_i      (rd_data),
    .rd_addr_i      (rd_addr),
    .resp_v_o       (resp_v_o),
    .resp_data_o    (resp_data_o),
    .resp_ch_addr_o (resp_ch_addr_o),
    .resp_yumi_i    (resp_yumi_i)
  );

endmodule

// ==== verif/tb_clock_gen.sv ====
// testbench clock and reset: 4 ns clock, reset low for 8 cycles, again on request
`timescale 1ns/1ps

module tb_clock_gen (
  input  logic reset_req_i,
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // reset only moves on falling edges
  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(negedge clk_o);
    rst_n_o = 1'b1;
    forever begin
      @(posedge clk_o);
      if (reset_req_i) begin
        @(negedge clk_o);
        rst_n_o = 1'b0;
        repeat (8) @(negedge clk_o);
        rst_n_o = 1'b1;
      end
    end
  end

endmodule

// ==== verif/hbm_test_bridge_asserts.sv ====
// handshake assertions for the hbm channel harness bound into its top level
`timescale 1ns/1ps

module hbm_test_bridge_asserts (
  input logic                clk_i,
  input logic                rst_n_i,
  input logic                ready_i,
  input logic                req_v_i,
  input logic                req_write_not_read_i,
  input logic                req_yumi_i,
  input logic                resp_v_i,
  input hbm_pkg::dram_data_t resp_data_i,
  input hbm_pkg::ch_addr_t   resp_ch_addr_i,
  input logic                resp_yumi_i
);

  import hbm_pkg::*;

  // reads taken and not yet popped
  int pending_r;

  // assertion failures so far
  int fail_cnt = 0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_r <= 0;
    end else begin
      pending_r <= pending_r + int'(req_yumi_i & ~req_write_not_read_i)
                   - int'(resp_v_i & resp_yumi_i);
    end
  end

  yumi_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_yumi_i |-> (req_v_i && ready_i))
    else begin
      fail_cnt++;
      $error("req_yumi_o high without req_v_i and ready_o");
    end

  head_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (resp_v_i && !resp_yumi_i) |=>
      (resp_v_i && $stable(resp_data_i) && $stable(resp_ch_addr_i)))
    else begin
      fail_cnt++;
      $error("response head changed before it was popped");
    end

  pending_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pending_r <= RESP_FIFO_DEPTH)
    else begin
      fail_cnt++;
      $error("more reads pending than the response queue holds");
    end

  ready_after_reset: assert property (@(posedge clk_i) !rst_n_i |=> !ready_i)
    else begin
      fail_cnt++;
      $error("ready_o high in the cycle after reset");
    end

endmodule

bind hbm_test_bridge hbm_test_bridge_asserts asserts_i (
  .clk_i                (clk_i),
  .rst_n_i              (rst_n_i),
  .ready_i              (ready_o),
  .req_v_i              (req_v_i),
  .req_write_not_read_i (req_write_not_read_i),
  .req_yumi_i           (req_yumi_o),
  .resp_v_i             (resp_v_o),
  .resp_data_i          (resp_data_o),
  .resp_ch_addr_i       (resp_ch_addr_o),
  .resp_yumi_i          (resp_yumi_i)
);

// ==== verif/hbm_test_bridge_tb.sv ====
// testbench for the hbm channel harness with random traffic against a shadow memory
`timescale 1ns/1ps

module hbm_test_bridge_tb;

  import hbm_pkg::*;

  localparam int WAIT_LIMIT  = 200;
  localparam int READY_LIMIT = NUM_WORDS + 100;

  logic       clk;
  logic       rst_n;
  logic       reset_req;
  logic       ready;
  logic       req_v;
  logic       req_we;
  logic       req_yumi;
  logic       resp_v;
  logic       resp_yumi;
  ch_addr_t   req_addr;
  ch_addr_t   resp_addr;
  ch_addr_t   written_q [$];
  ch_addr_t   exp_addr_q [$];
  dram_data_t req_data;
  dram_data_t resp_data;
  dram_data_t shadow [NUM_WORDS];
  dram_data_t exp_data_q [$];
  integer     seed = 32'h584d_135d;
  int         data_errors = 0;
  int         addr_errors = 0;
  int         flag_errors = 0;
  int         other_errors = 0;

  tb_clock_gen clk_gen (
    .reset_req_i (reset_req),
    .clk_o       (clk),
    .rst_n_o     (rst_n)
  );

  hbm_test_bridge dut_i (
    .clk_i                (clk),
    .rst_n_i              (rst_n),
    .ready_o              (ready),
    .req_v_i              (req_v),
    .req_write_not_read_i (req_we),
    .req_ch_addr_i        (req_addr),
    .req_data_i           (req_data),
    .req_yumi_o           (req_yumi),
    .resp_v_o             (resp_v),
    .resp_data_o          (resp_data),
    .resp_ch_addr_o       (resp_addr),
    .resp_yumi_i          (resp_yumi)
  );

  // ------------------------------------------------------------------------
  // reference and checks
  // ------------------------------------------------------------------------
  // shadow indexed by the cache-order word address
  function automatic void ref_read(input ch_addr_t addr, output dram_data_t exp_data,
                                   output ch_addr_t exp_addr);
    exp_data = shadow[addr[CH_ADDR_WIDTH-1:BYTE_OFFSET_WIDTH]];
    exp_addr = addr;
  endfunction

  // ba, bg, row, column and byte offset all differ between k values
  function automatic ch_addr_t burst_addr(input int i);
    logic [1:0] k;
    k = i[1:0];
    return {k, ~k, {k, ~k}, {k, ~k, k[0]}, k};
  endfunction

  task automatic check_data(input dram_data_t got, input dram_data_t exp, input ch_addr_t addr);
    if (got !== exp) begin
      data_errors++;
      $display("FAILED %0t: data 0x%08h at addr 0x%04h, expected 0x%08h", $time, got, addr, exp);
    end
  endtask

  task automatic check_addr(input ch_addr_t got, input ch_addr_t exp);
    if (got !== exp) begin
      addr_errors++;
      $display("FAILED %0t: response addr 0x%04h, expected 0x%04h", $time, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      flag_errors++;
      $display("FAILED %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report_and_finish();
    int assert_errors;
    assert_errors = dut_i.asserts_i.fail_cnt;
    $display("errors: data %0d, addr %0d, flag %0d, other %0d, assert %0d",
             data_errors, addr_errors, flag_errors, other_errors, assert_errors);
    if (data_errors + addr_errors + flag_errors + other_errors + assert_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  task automatic timed_out(input string what);
    other_errors++;
    $display("timeout while waiting for %s", what);
    report_and_finish();
  endtask

  // ------------------------------------------------------------------------
  // stimulus entered at a falling edge
  // ------------------------------------------------------------------------
  task automatic try_request(input logic we, input ch_addr_t addr, input dram_data_t data,
                             output logic taken);
    dram_data_t e_data;
    ch_addr_t   e_addr;
    req_v    = 1'b1;
    req_we   = we;
    req_addr = addr;
    req_data = data;
    #1;
    taken = req_yumi;
    if (taken && we) begin
      shadow[addr[CH_ADDR_WIDTH-1:BYTE_OFFSET_WIDTH]] = data;
    end else if (taken) begin
      ref_read(addr, e_data, e_addr);
      exp_data_q.push_back(e_data);
      exp_addr_q.push_back(e_addr);
    end
    @(negedge clk);
    req_v = 1'b0;
  endtask

  task automatic do_request(input logic we, input ch_addr_t addr, input dram_data_t data);
    logic taken;
    int   n;
    taken = 1'b0;
    n = 0;
    while (!taken && n < WAIT_LIMIT) begin
      try_request(we, addr, data, taken);
      n++;
    end
    if (!taken) timed_out("request acceptance");
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (ready !== 1'b1 && n < READY_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (ready !== 1'b1) timed_out("ready_o after reset");
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_data_q.size() != 0 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (exp_data_q.size() != 0) timed_out("responses to all accepted reads");
  endtask

  task automatic wait_resp_valid();
    int n;
    n = 0;
    while (resp_v !== 1'b1 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (resp_v !== 1'b1) timed_out("resp_v_o with reads queued");
  endtask

  task automatic wait_reset_low();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (rst_n && n < WAIT_LIMIT);
    if (rst_n) timed_out("reset assertion");
    @(negedge clk);
  endtask

  // one pop per response handshake at the coming rising edge
  initial begin : compare_resp
    dram_data_t e_data;
    ch_addr_t   e_addr;
    forever begin
      @(negedge clk);
      #1;
      if (rst_n && resp_v && resp_yumi) begin
        if (exp_data_q.size() == 0) begin
          other_errors++;
          $display("response at %0t with no read outstanding", $time);
        end else begin
          e_data = exp_data_q.pop_front();
          e_addr = exp_addr_q.pop_front();
          check_data(resp_data, e_data, e_addr);
          check_addr(resp_addr, e_addr);
        end
      end
    end
  end

  initial begin : main_seq
    ch_addr_t   addr;
    dram_data_t data;
    int         accepted;
    logic       taken;
    {req_v, req_we, reset_req, req_addr, req_data} = '0;
    resp_yumi = 1'b1;
    foreach (shadow[i]) shadow[i] = '0;
    @(negedge clk);
    wait_ready();

    // never-written words come back as zero
    for (int i = 0; i < 8; i++) do_request(1'b0, ch_addr_t'($random(seed)), '0);
    wait_drain();

    // random writes read back at once and then in random order
    for (int i = 0; i < 16; i++) begin
      addr = ch_addr_t'($random(seed));
      data = dram_data_t'($random(seed));
      do_request(1'b1, addr, data);
      do_request(1'b0, addr, '0);
      written_q.push_back(addr);
    end
    for (int i = 0; i < 16; i++) begin
      do_request(1'b0, written_q[$unsigned($random(seed)) % written_q.size()], '0);
    end
    wait_drain();

    // back-to-back burst
    for (int i = 0; i < 4; i++) do_request(1'b1, burst_addr(i), 32'hc0de_0000 + i);
    for (int i = 0; i < 8; i++) do_request(1'b0, burst_addr(i), '0);
    wait_drain();

    // back-pressure
    resp_yumi = 1'b0;
    accepted = 0;
    for (int i = 0; i < 20; i++) begin
      try_request(1'b0, burst_addr(accepted), '0, taken);
      if (taken) accepted++;
    end
    check_flag(accepted == RESP_FIFO_DEPTH, 1'b1, "reads taken equal to queue depth");
    resp_yumi = 1'b1;
    wait_drain();

    // reset with reads queued and still in flight
    for (int i = 0; i < 4; i++) do_request(1'b1, written_q[i], $random(seed) | 32'h1);
    resp_yumi = 1'b0;
    for (int i = 0; i < 4; i++) do_request(1'b0, written_q[i], '0);
    wait_resp_valid();
    reset_req = 1'b1;
    wait_reset_low();
    reset_req = 1'b0;
    check_flag(ready, 1'b0, "ready_o in reset");
    check_flag(resp_v, 1'b0, "resp_v_o in reset");
    exp_data_q.delete();
    exp_addr_q.delete();
    foreach (shadow[i]) shadow[i] = '0;
    resp_yumi = 1'b1;
    wait_ready();
    for (int i = 0; i < 4; i++) do_request(1'b0, written_q[i], '0);
    wait_drain();
    report_and_finish();
  end

endmodule

// ==== hbm_test_bridge.f ====
logic/hbm_pkg.sv
logic/dram_req_ctrl.sv
logic/dram_channel_model.sv
logic/read_resp_fifo.sv
logic/hbm_test_bridge.sv
verif/tb_clock_gen.sv
verif/hbm_test_bridge_asserts.sv
verif/hbm_test_bridge_tb.sv

// ==== Makefile ====
TOP := hbm_test_bridge_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): hbm_test_bridge.f $(wildcard logic/*.sv verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f hbm_test_bridge.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -q ">>> FAIL" sim.log; then echo "simulation reported errors"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
